// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
FILELIST  ?= load_store_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: load_store_unit.f
source/lsu_access_pkg.sv
source/lsu_bus_pkg.sv
source/lsu_request_align.sv
source/lsu_outstanding_ctrl.sv
source/lsu_rdata_align.sv
source/load_store_unit.sv
tb/lsu_bus_memory.sv
tb/tb_load_store_unit.sv

// File: source/load_store_unit.sv
// Data side load/store unit
`timescale 1ns/1ps

module load_store_unit (
  input  logic                  clk,
  input  logic                  rst_n,

  // Execute stage request
  input  logic                  valid_0_i,
  input  logic                  we_i,
  input  lsu_access_pkg::size_e size_i,
  input  logic                  sext_i,
  input  lsu_access_pkg::word_t base_i,
  input  lsu_access_pkg::word_t offset_i,
  input  lsu_access_pkg::word_t wdata_i,
  output logic                  ready_0_o,

  // Write-back result
  output logic                  valid_1_o,
  output lsu_access_pkg::word_t rdata_1_o,

  // Data bus
  output logic                  bus_req_o,
  input  logic                  bus_gnt_i,
  output lsu_access_pkg::word_t bus_addr_o,
  output logic                  bus_we_o,
  output lsu_bus_pkg::be_t      bus_be_o,
  output lsu_access_pkg::word_t bus_wdata_o,
  input  logic                  bus_rvalid_i,
  input  lsu_access_pkg::word_t bus_rdata_i
);

  logic                    req_accept;
  logic                    split;
  logic                    last_phase;
  lsu_access_pkg::offset_t byte_off;

  // Direction comes straight from the execute stage
  assign bus_we_o = we_i;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  lsu_request_align u_request_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_0_i      (valid_0_i),
    .we_i           (we_i),
    .size_i         (size_i),
    .base_i         (base_i),
    .offset_i       (offset_i),
    .wdata_i        (wdata_i),
    .req_accept_i   (req_accept),
    .bus_addr_o     (bus_addr_o),
    .bus_be_o       (bus_be_o),
    .bus_wdata_o    (bus_wdata_o),
    .split_o        (split),
    .second_phase_o (),
    .last_phase_o   (last_phase),
    .offset_o       (byte_off)
  );

  // Request gating and execute stage handshake
  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_0_i    (valid_0_i),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .last_phase_i (last_phase),
    .bus_req_o    (bus_req_o),
    .req_accept_o (req_accept),
    .ready_0_o    (ready_0_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_accept_i (req_accept),
    .we_i         (we_i),
    .size_i       (size_i),
    .sext_i       (sext_i),
    .offset_i     (byte_off),
    .split_i      (split),
    .last_phase_i (last_phase),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .valid_1_o    (valid_1_o),
    .rdata_1_o    (rdata_1_o)
  );

endmodule

// File: source/lsu_access_pkg.sv
// Load/store access definitions
package lsu_access_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data and address words
  ////////////////////////////////////////////////////////////////////////////

  // One 32-bit data word or byte address
  typedef logic [31:0] word_t;

  // Byte position inside a word
  typedef logic [1:0] offset_t;

  ////////////////////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////////////////////

  // Encoding follows the execute stage size field
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // Distance in bytes from one word to the next
  localparam int unsigned ADDR_ALIGN_STEP = 4;

endpackage

// File: source/lsu_bus_pkg.sv
// Data bus transaction definitions
package lsu_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // One enable per byte lane, lane 0 is the least significant byte
  typedef logic [3:0] be_t;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding transactions
  ////////////////////////////////////////////////////////////////////////////

  // Granted requests still waiting for their response
  localparam int unsigned OUTSTANDING_DEPTH = 2;

  // Wide enough to hold 0 up to OUTSTANDING_DEPTH
  typedef logic [1:0] cnt_t;

endpackage

// File: source/lsu_outstanding_ctrl.sv
// Outstanding transaction control
`timescale 1ns/1ps

module lsu_outstanding_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  input  logic last_phase_i,
  output logic bus_req_o,
  output logic req_accept_o,
  output logic ready_0_o
);

  lsu_bus_pkg::cnt_t cnt_q;
  lsu_bus_pkg::cnt_t cnt_d;
  logic              below_depth;

  ////////////////////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////////////////////

  // Room for one more transaction in flight
  assign below_depth = (cnt_q < lsu_bus_pkg::cnt_t'(lsu_bus_pkg::OUTSTANDING_DEPTH));

  // Counter only drops while waiting, so a raised request stays up
  assign bus_req_o = valid_0_i && below_depth;

  // Address phase done on this edge
  assign req_accept_o = bus_req_o && bus_gnt_i;

  // Execute stage moves on only after its last phase is granted
  assign ready_0_o = req_accept_o && last_phase_i;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////////////////////

  // Grant and response together cancel out
  always_comb begin
    case ({req_accept_o, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Gating must hold the count at or below depth
  a_cnt_le_depth : assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_bus_pkg::cnt_t'(lsu_bus_pkg::OUTSTANDING_DEPTH)
  ) else $error("outstanding count above depth");

  // Bus must not answer a request that was never granted
  a_no_orphan_rsp : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0)
  ) else $error("response with no outstanding request");

endmodule

// File: source/lsu_rdata_align.sv
// Read data realignment and extension
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_accept_i,
  input  logic                    we_i,
  input  lsu_access_pkg::size_e   size_i,
  input  logic                    sext_i,
  input  lsu_access_pkg::offset_t offset_i,
  input  logic                    split_i,
  input  logic                    last_phase_i,
  input  logic                    bus_rvalid_i,
  input  lsu_access_pkg::word_t   bus_rdata_i,
  output logic                    valid_1_o,
  output lsu_access_pkg::word_t   rdata_1_o
);

  localparam int unsigned PTR_W = $clog2(lsu_bus_pkg::OUTSTANDING_DEPTH);

  // Attribute queue, one entry per granted request
  lsu_access_pkg::size_e   q_size   [lsu_bus_pkg::OUTSTANDING_DEPTH];
  logic                    q_sext   [lsu_bus_pkg::OUTSTANDING_DEPTH];
  lsu_access_pkg::offset_t q_offset [lsu_bus_pkg::OUTSTANDING_DEPTH];
  logic                    q_we     [lsu_bus_pkg::OUTSTANDING_DEPTH];
  logic                    q_split  [lsu_bus_pkg::OUTSTANDING_DEPTH];
  logic                    q_last   [lsu_bus_pkg::OUTSTANDING_DEPTH];

  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  lsu_bus_pkg::cnt_t     level_q;
  logic                  half_q;
  lsu_access_pkg::word_t rdata_q;
  logic [63:0]           rdata_full;
  logic [63:0]           rdata_shift;

  ////////////////////////////////////////////////////////////////////////////
  // Attribute queue
  ////////////////////////////////////////////////////////////////////////////

  // Payload, written at the grant edge
  always_ff @(posedge clk) begin
    if (req_accept_i) begin
      q_size[wr_ptr_q]   <= size_i;
      q_sext[wr_ptr_q]   <= sext_i;
      q_offset[wr_ptr_q] <= offset_i;
      q_we[wr_ptr_q]     <= we_i;
      q_split[wr_ptr_q]  <= split_i;
      q_last[wr_ptr_q]   <= last_phase_i;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (req_accept_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (bus_rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({req_accept_i, bus_rvalid_i})
        2'b10:   level_q <= level_q + 2'd1;
        2'b01:   level_q <= level_q - 2'd1;
        default: level_q <= level_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // First half capture
  ////////////////////////////////////////////////////////////////////////////

  // Lower half pending once the first phase of a split has answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (bus_rvalid_i) begin
      half_q <= q_split[rd_ptr_q];
    end
  end

  // Raw word of the first phase, loads only
  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !q_we[rd_ptr_q] && !q_last[rd_ptr_q]) begin
      rdata_q <= bus_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////////////////////

  // Unsplit word doubled so the shift wraps its upper bytes down
  assign rdata_full  = half_q ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};
  assign rdata_shift = rdata_full >> (7'(q_offset[rd_ptr_q]) * 7'd8);

  always_comb begin
    case (q_size[rd_ptr_q])
      lsu_access_pkg::SIZE_BYTE:
        rdata_1_o = {{24{q_sext[rd_ptr_q] && rdata_shift[7]}}, rdata_shift[7:0]};
      lsu_access_pkg::SIZE_HALF:
        rdata_1_o = {{16{q_sext[rd_ptr_q] && rdata_shift[15]}}, rdata_shift[15:0]};
      default:
        rdata_1_o = rdata_shift[31:0];
    endcase
  end

  // One pulse per access, on its final response
  assign valid_1_o = bus_rvalid_i && q_last[rd_ptr_q];

  // Queue level tracks the outstanding count in the controller
  a_queue_bounds : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((req_accept_i && !bus_rvalid_i) |->
       (level_q < lsu_bus_pkg::cnt_t'(lsu_bus_pkg::OUTSTANDING_DEPTH))) and
    (bus_rvalid_i |-> (level_q != '0))
  ) else $error("attribute queue pushed full or popped empty");

endmodule

// File: source/lsu_request_align.sv
// Request address and data alignment
`timescale 1ns/1ps

module lsu_request_align (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_0_i,
  input  logic                    we_i,
  input  lsu_access_pkg::size_e   size_i,
  input  lsu_access_pkg::word_t   base_i,
  input  lsu_access_pkg::word_t   offset_i,
  input  lsu_access_pkg::word_t   wdata_i,
  input  logic                    req_accept_i,
  output lsu_access_pkg::word_t   bus_addr_o,
  output lsu_bus_pkg::be_t        bus_be_o,
  output lsu_access_pkg::word_t   bus_wdata_o,
  output logic                    split_o,
  output logic                    second_phase_o,
  output logic                    last_phase_o,
  output lsu_access_pkg::offset_t offset_o
);

  lsu_access_pkg::word_t   addr;
  lsu_access_pkg::word_t   addr_next_word;
  lsu_access_pkg::offset_t byte_off;
  lsu_bus_pkg::be_t        size_mask;
  logic [7:0]              be_span;
  logic [63:0]             wdata_dbl;
  logic                    phase_q;

  // Effective address
  assign addr     = base_i + offset_i;
  assign byte_off = addr[1:0];
  assign offset_o = byte_off;

  // Next word for the spill half of a split access
  assign addr_next_word = {addr[31:2], 2'b00} + lsu_access_pkg::word_t'(
                            lsu_access_pkg::ADDR_ALIGN_STEP);

  ////////////////////////////////////////////////////////////////////////////
  // Split detection and phase tracking
  ////////////////////////////////////////////////////////////////////////////

  // Crossing first phase only, never while the second phase is active
  always_comb begin
    split_o = 1'b0;
    if (valid_0_i && !phase_q) begin
      case (size_i)
        lsu_access_pkg::SIZE_WORD: split_o = (byte_off != 2'b00);
        lsu_access_pkg::SIZE_HALF: split_o = (byte_off == 2'b11);
        default:                   split_o = 1'b0;
      endcase
    end
  end

  assign last_phase_o   = !split_o;
  assign second_phase_o = phase_q;

  // Set by a granted crossing first phase, cleared by the granted second phase
  // Dropped valid also clears it so the next access starts in phase one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= 1'b0;
    end else if (!valid_0_i) begin
      phase_q <= 1'b0;
    end else if (req_accept_i) begin
      phase_q <= split_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus address, byte enables, write data
  ////////////////////////////////////////////////////////////////////////////

  assign bus_addr_o = phase_q ? addr_next_word : addr;

  // Lanes touched by the access, before shifting into place
  always_comb begin
    case (size_i)
      lsu_access_pkg::SIZE_BYTE: size_mask = 4'b0001;
      lsu_access_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:                   size_mask = 4'b1111;
    endcase
  end

  // Upper nibble holds the lanes that spilled into the next word
  assign be_span  = {4'b0000, size_mask} << (4'(byte_off));
  assign bus_be_o = phase_q ? be_span[7:4] : be_span[3:0];

  // Rotate left by the byte offset; the same rotation serves both phases
  assign wdata_dbl   = {wdata_i, wdata_i} << (6'(byte_off) * 6'd8);
  assign bus_wdata_o = we_i ? wdata_dbl[63:32] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // A stale second phase would corrupt the next access
  a_phase_clears_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!valid_0_i ##1 !valid_0_i) |-> !second_phase_o
  ) else $error("second phase flag held while execute stage idle");

endmodule

// File: tb/lsu_bus_memory.sv
// Randomized data bus memory
`timescale 1ns/1ps

module lsu_bus_memory #(
  parameter logic [31:0] SEED = 32'h0000_0001
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        bus_req_i,
  output logic        bus_gnt_o,
  input  logic [31:0] bus_addr_i,
  input  logic        bus_we_i,
  input  logic [3:0]  bus_be_i,
  input  logic [31:0] bus_wdata_i,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o
);

  // 256-byte window, upper address bits ignored
  logic [7:0]  mem [256];
  logic [31:0] gnt_rng;
  logic [31:0] dly_rng;
  int unsigned cycle;
  int unsigned last_due;
  logic        pend_valid;
  logic [31:0] pend_data;
  // Responses waiting for their slot, oldest first
  logic [31:0] rsp_data [$];
  int unsigned rsp_due  [$];

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Power-up content, distinct per byte address
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return {a[3:0], a[7:4]} ^ 8'ha5;
  endfunction

  initial begin
    gnt_rng      = SEED;
    dly_rng      = ~SEED;
    cycle        = 0;
    last_due     = 0;
    pend_valid   = 1'b0;
    pend_data    = '0;
    bus_gnt_o    = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_rdata_o  = '0;
    for (int a = 0; a < 256; a++) begin
      mem[8'(a)] = fill_byte(8'(a));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address phase and response scheduling
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [7:0]  base;
    logic [31:0] word;
    int unsigned due;
    cycle      = cycle + 1;
    pend_valid = 1'b0;
    if (!rst_n) begin
      rsp_data.delete();
      rsp_due.delete();
      last_due = cycle;
    end else begin
      if (bus_req_i && bus_gnt_o) begin
        base = {bus_addr_i[7:2], 2'b00};
        // Stores land at the grant, loads read at the grant
        for (int i = 0; i < 4; i++) begin
          if (bus_we_i && bus_be_i[i]) begin
            mem[base + 8'(i)] = bus_wdata_i[8*i +: 8];
          end
          word[8*i +: 8] = mem[base + 8'(i)];
        end
        // One to three cycles, never overtaking an older response
        dly_rng = xorshift32(dly_rng);
        due     = cycle + 1 + (dly_rng % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data.push_back(bus_we_i ? 32'h0 : word);
        rsp_due.push_back(due);
      end
      // Head response goes out on the next falling edge
      if (rsp_due.size() != 0 && rsp_due[0] <= cycle + 1) begin
        pend_valid = 1'b1;
        pend_data  = rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end
    end
  end

  // Grant about three cycles in four
  always @(negedge clk) begin
    gnt_rng      = xorshift32(gnt_rng);
    bus_gnt_o    = rst_n && (gnt_rng[1:0] != 2'b00);
    bus_rvalid_o = pend_valid;
    bus_rdata_o  = pend_data;
  end

endmodule

// File: tb/tb_load_store_unit.sv
// Load/store unit testbench
`timescale 1ns/1ps

module tb_load_store_unit;

  localparam int unsigned CLK_HALF     = 20;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned NUM_WORDS    = 16;
  localparam int unsigned NUM_ACCESS   = 400;
  // Sixteen cycles per access covers grant and response delays
  localparam int unsigned CYCLE_LIMIT  = NUM_ACCESS * 16 + RESET_CYCLES;
  localparam logic [31:0] RNG_SEED     = 32'h5a88b5a5;

  // Core side
  logic                  clk, rst_n, valid_0_i, we_i, sext_i;
  lsu_access_pkg::size_e size_i;
  logic [31:0]           base_i, offset_i, wdata_i, rdata_1_o;
  logic                  ready_0_o, valid_1_o;
  // Bus side
  logic                  bus_req_o, bus_gnt_i, bus_we_o, bus_rvalid_i;
  logic [3:0]            bus_be_o;
  logic [31:0]           bus_addr_o, bus_wdata_o, bus_rdata_i;

  // Byte image of the bus memory, updated in issue order
  logic [7:0]  model_mem [256];
  // One entry per accepted access, oldest first
  logic [31:0] exp_rdata [$];
  logic        exp_load  [$];
  logic [31:0] rng;
  int unsigned errors;
  int unsigned checks;
  int unsigned cycles;
  // Granted requests still waiting for their response
  int          in_flight;

  load_store_unit uut (.*);

  lsu_bus_memory #(.SEED(RNG_SEED ^ 32'h0f0f_3c3c)) u_bus_memory (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req_o),
    .bus_gnt_o    (bus_gnt_i),
    .bus_addr_i   (bus_addr_o),
    .bus_we_i     (bus_we_o),
    .bus_be_i     (bus_be_o),
    .bus_wdata_i  (bus_wdata_o),
    .bus_rvalid_o (bus_rvalid_i),
    .bus_rdata_o  (bus_rdata_i)
  );

  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Must match the power-up content of the bus memory
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return {a[3:0], a[7:4]} ^ 8'ha5;
  endfunction

  // Little-endian assembly, then sign or zero fill above the access
  function automatic logic [31:0] predict_load(input logic [31:0] addr, input int n,
                                               input logic sx);
    logic [31:0] v;
    logic        msb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = model_mem[8'(addr + 32'(i))];
    end
    msb = sx && v[8*n-1];
    for (int i = n; i < 4; i++) begin
      v[8*i +: 8] = {8{msb}};
    end
    return v;
  endfunction

  // Data byte expected on each lane, by its distance from the access address
  function automatic logic [31:0] lane_data(input logic [31:0] addr, input int unsigned phase,
                                            input logic [31:0] data);
    logic [31:0] v;
    int          d;
    v = '0;
    for (int j = 0; j < 4; j++) begin
      d = 4 * int'(phase) + j - int'(addr[1:0]);
      if (d >= 0 && d < 4) begin
        v[8*j +: 8] = data[8*d +: 8];
      end
    end
    return v;
  endfunction

  task automatic apply_store(input logic [31:0] addr, input int n, input logic [31:0] data);
    for (int i = 0; i < n; i++) begin
      model_mem[8'(addr + 32'(i))] = data[8*i +: 8];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Fail at %0d ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid_0_i = 1'b0;
  endtask

  // One access, held until its last phase is granted
  task automatic run_access(input logic we, input logic [1:0] sz, input logic sx,
                            input logic [31:0] base, input logic [31:0] off,
                            input logic [31:0] data);
    logic [31:0] addr;
    logic [7:0]  span;
    logic [3:0]  be_exp;
    logic [31:0] lane_mask;
    int unsigned n;
    int unsigned nph;
    int unsigned phase;
    logic        done;
    addr  = base + off;
    n     = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : 4;
    // Upper nibble holds lanes spilling into the next word
    span  = 8'((1 << n) - 1) << addr[1:0];
    nph   = (span[7:4] != 4'h0) ? 2 : 1;
    phase = 0;
    done  = 1'b0;
    @(negedge clk);
    valid_0_i = 1'b1;
    we_i      = we;
    size_i    = lsu_access_pkg::size_e'(sz);
    sext_i    = sx;
    base_i    = base;
    offset_i  = off;
    wdata_i   = data;
    while (!done) begin
      @(posedge clk);
      if (bus_req_o && bus_gnt_i) begin
        be_exp = (phase == 0) ? span[3:0] : span[7:4];
        for (int j = 0; j < 4; j++) begin
          lane_mask[8*j +: 8] = {8{be_exp[j]}};
        end
        check_value("bus_addr_o", (phase == 0) ? addr : {addr[31:2], 2'b00} + 32'd4,
                    bus_addr_o);
        check_value("bus_be_o", 32'(be_exp), 32'(bus_be_o));
        check_value("bus_we_o", 32'(we), 32'(bus_we_o));
        // Only the enabled lanes carry store data
        if (we) begin
          check_value("bus_wdata_o", lane_data(addr, phase, data) & lane_mask,
                      bus_wdata_o & lane_mask);
        end
        check_value("ready_0_o", 32'(phase == nph - 1), 32'(ready_0_o));
        phase++;
        done = ready_0_o || (phase >= nph);
      end else begin
        // No acceptance without a grant
        check_value("ready_0_o", 32'h0, 32'(ready_0_o));
      end
    end
    if (we) begin
      apply_store(addr, n, data);
      exp_rdata.push_back(32'h0);
    end else begin
      exp_rdata.push_back(predict_load(addr, n, sx));
    end
    exp_load.push_back(!we);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result monitor and run limit
  ////////////////////////////////////////////////////////////////////////////

  // Exactly one result per access, in issue order
  always @(posedge clk) begin
    logic [31:0] expd;
    logic        is_load;
    if (rst_n && valid_1_o) begin
      assert (exp_load.size() != 0) else begin
        errors++;
        $display("Result returned at %0d ns with no access outstanding", $time);
      end
      if (exp_load.size() != 0) begin
        is_load = exp_load.pop_front();
        expd    = exp_rdata.pop_front();
        if (is_load) begin
          check_value("rdata_1_o", expd, rdata_1_o);
        end
      end
    end
  end

  // Request follows valid only while fewer than two transactions are in flight
  always @(posedge clk) begin
    logic exp_req;
    if (!rst_n) begin
      in_flight = 0;
    end else begin
      exp_req = valid_0_i && (in_flight < lsu_bus_pkg::OUTSTANDING_DEPTH);
      check_value("bus_req_o", 32'(exp_req), 32'(bus_req_o));
      if (exp_req && bus_gnt_i) begin
        in_flight++;
      end
      if (bus_rvalid_i) begin
        in_flight--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with accesses still pending", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    logic [1:0]  sz;
    rng       = RNG_SEED;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    rst_n     = 1'b0;
    valid_0_i = 1'b0;
    we_i      = 1'b0;
    size_i    = lsu_access_pkg::SIZE_BYTE;
    sext_i    = 1'b0;
    base_i    = '0;
    offset_i  = '0;
    wdata_i   = '0;
    for (int a = 0; a < 256; a++) begin
      model_mem[8'(a)] = fill_byte(8'(a));
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Quiet bus and handshake while the execute stage is idle
    repeat (4) begin
      @(posedge clk);
      check_value("bus_req_o", 32'h0, 32'(bus_req_o));
      check_value("ready_0_o", 32'h0, 32'(ready_0_o));
      check_value("valid_1_o", 32'h0, 32'(valid_1_o));
    end

    // Aligned words written, then read back
    for (int i = 0; i < NUM_WORDS; i++) begin
      rng = xorshift32(rng);
      run_access(1'b1, 2'd2, 1'b0, 32'h1000, 32'(i * 16), rng);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      run_access(1'b0, 2'd2, 1'b0, 32'h1000, 32'(i * 16), 32'h0);
    end

    // Mixed sizes at every offset, with the odd idle cycle
    for (int i = 2 * NUM_WORDS; i < NUM_ACCESS; i++) begin
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      if (r[31:29] == 3'd0) begin
        idle_cycle();
      end
      sz = (r[2:1] == 2'd3) ? 2'd2 : r[2:1];
      run_access(r[0], sz, r[3], 32'h1000 + {24'h0, r[11:4]}, {29'h0, r[14:12]}, rng);
    end

    // Drain what is still in flight
    idle_cycle();
    while (exp_load.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
